// File: files.f
verilog/woz_pkg.sv
verilog/dual_port_ram.sv
verilog/sd_block_reader.sv
verilog/woz_chunk_parser.sv
verilog/track_entry_lookup.sv
verilog/disk_controller.sv
verilog/woz_track_loader.sv
sim/woz_image_model.sv
sim/tb_woz_track_loader.sv

// File: Makefile
VERILATOR  = verilator
TOP        = tb_woz_track_loader
FILE_LIST  = files.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FLAGS      = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing -Wall
FAIL_MSG   = Test failed
PASS_MSG   = Test passed

SOURCES = $(shell cat $(FILE_LIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_woz_track_loader.sv
module tb_woz_track_loader
    import woz_pkg::*;
;

    localparam int SCAN_LIMIT  = 8;
    localparam int IMAGE_BYTES = 16384;
    localparam int WAIT_LIMIT  = 20000;

    logic                    clk;
    logic                    reset;
    lba_t                    sd_lba;
    logic                    sd_rd;
    logic                    sd_ack;
    logic [BUFF_ADDR_W-1:0]  sd_buff_addr;
    byte_t                   sd_buff_dout;
    logic                    sd_buff_wr;
    logic                    img_mounted;
    track_id_t               track_id;
    logic                    ready;
    logic                    disk_mounted;
    logic                    busy;
    logic [31:0]             bit_count;
    logic [TRACK_ADDR_W-1:0] bit_addr;
    byte_t                   bit_data;
    int                      blocks_served;

    byte_t  image [IMAGE_BYTES];
    integer seed;
    int     value_errors;
    int     other_errors;
    int     first_block;
    string  test_name;

    // Compare pipeline and bus monitor controls
    logic                    probe_valid;
    byte_t                   probe_expect;
    logic                    stage_valid;
    byte_t                   stage_expect;
    logic [TRACK_ADDR_W-1:0] stage_addr;
    logic                    lba_watch;
    lba_t                    lba_low;
    lba_t                    lba_high;
    logic                    ready_watch;
    logic                    ready_seen;

    woz_track_loader #(.SCAN_BLOCK_LIMIT(SCAN_LIMIT)) UUT (.*);

    woz_image_model #(.IMAGE_BYTES(IMAGE_BYTES)) img_model (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ==================================================
    // Image builder
    // ==================================================
    function automatic void put_le(input int pos, input int value, input int bytes);
        for (int i = 0; i < bytes; i++) begin
            image[pos + i] = byte_t'(value >> (8 * i));
        end
    endfunction

    function automatic void put_chunk(input int pos, input logic [31:0] id, input int size);
        {image[pos], image[pos + 1], image[pos + 2], image[pos + 3]} = id;
        put_le(pos + 4, size, 4);
    endfunction

    function automatic void build_image(input logic with_trks);
        int block;
        block = 3;
        for (int i = 0; i < IMAGE_BYTES; i++) begin
            image[i] = byte_t'($random(seed));
        end
        // Signature, high-bit check and line ends, CRC left at zero
        {image[0], image[1], image[2], image[3]} = 32'h574F_5A32;
        {image[4], image[5], image[6], image[7]} = 32'hFF0A_0D0A;
        put_le(8, 0, 4);
        put_chunk(12, CHUNK_INFO, 60);
        put_le(20, 16'h0102, 2);
        put_chunk(80, CHUNK_TMAP, TMAP_ENTRIES);
        // Tracks 0 to 3 use entries 0 to 3, the rest are empty
        for (int t = 0; t < TMAP_ENTRIES; t++) begin
            image[88 + t] = (t < 4) ? byte_t'(t) : TMAP_EMPTY;
        end
        if (with_trks) begin
            put_chunk(248, CHUNK_TRKS, TRKS_BYTES);
            for (int i = 256; i < 1536; i++) begin
                image[i] = 8'h00;
            end
            // Track data starts at block 3, right after TRKS
            for (int e = 0; e < 4; e++) begin
                put_le(256 + 8 * e, block, 2);
                put_le(258 + 8 * e, 2 + e % 2, 2);
                put_le(260 + 8 * e, $random(seed) & 32'h0000_FFFF, 4);
                block = block + 2 + e % 2;
            end
        end else begin
            // Past TMAP only empty chunk headers follow
            for (int i = 248; i < IMAGE_BYTES; i++) begin
                image[i] = 8'h00;
            end
        end
        for (int i = 0; i < IMAGE_BYTES; i++) begin
            img_model.image[i] = image[i];
        end
    endfunction

    // ==================================================
    // Reference model
    // ==================================================
    function automatic int get_le(input int pos, input int bytes);
        int value;
        value = 0;
        for (int i = bytes - 1; i >= 0; i--) begin
            value = (value << 8) | int'(image[pos + i]);
        end
        return value;
    endfunction

    // Body offset of a chunk, or -1 when the walk does not find it
    function automatic int find_chunk(input logic [31:0] id);
        int pos;
        pos = WOZ_HEADER_BYTES;
        while (pos + 8 <= IMAGE_BYTES && pos >= 0) begin
            if ({image[pos], image[pos + 1], image[pos + 2], image[pos + 3]} == id) begin
                return pos + 8;
            end
            pos = pos + 8 + get_le(pos + 4, 4);
        end
        return -1;
    endfunction

    function automatic int entry_offset(input int track);
        byte_t index;
        index = image[find_chunk(CHUNK_TMAP) + track];
        if (index == TMAP_EMPTY) begin
            return -1;
        end
        return find_chunk(CHUNK_TRKS) + 8 * int'(index);
    endfunction

    function automatic int ref_start(input int track);
        return (entry_offset(track) < 0) ? 0 : get_le(entry_offset(track), 2);
    endfunction

    function automatic int ref_blocks(input int track);
        return (entry_offset(track) < 0) ? 0 : get_le(entry_offset(track) + 2, 2);
    endfunction

    function automatic logic [31:0] ref_bit_count(input int track);
        return (entry_offset(track) < 0) ? 32'd0 : get_le(entry_offset(track) + 4, 4);
    endfunction

    function automatic byte_t ref_byte(input int track, input int offset);
        return image[512 * ref_start(track) + offset];
    endfunction

    // ==================================================
    // Checks and waits
    // ==================================================
    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic wait_status(input logic on_ready, input logic level);
        int cycles;
        cycles = 0;
        while ((on_ready ? ready : busy) !== level && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if ((on_ready ? ready : busy) !== level) begin
            $display("%s: timed out waiting for %s to become %0d", test_name,
                     on_ready ? "ready" : "busy", level);
            other_errors++;
        end
    endtask

    // Random reads over the loaded part of the track
    task automatic sample_track(input int track, input int samples);
        int span;
        int offset;
        span = 512 * ref_blocks(track);
        for (int i = 0; i < samples; i++) begin
            @(negedge clk);
            offset       = int'($unsigned($random(seed)) % span);
            bit_addr     = TRACK_ADDR_W'(offset);
            probe_expect = ref_byte(track, offset);
            probe_valid  = 1'b1;
        end
        @(negedge clk);
        probe_valid = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    // bit_data answers the address sampled one clock earlier
    always @(posedge clk) begin
        if (stage_valid) begin
            assert (bit_data === stage_expect) else begin
                $display("error %s data at %0h: expected %0h, actual %0h", test_name,
                         stage_addr, stage_expect, bit_data);
                value_errors++;
            end
        end
        stage_valid  = probe_valid;
        stage_expect = probe_expect;
        stage_addr   = bit_addr;
    end

    // Block requests must stay inside the track being loaded
    always @(posedge clk) begin
        if (lba_watch && sd_rd) begin
            assert (sd_lba >= lba_low && sd_lba < lba_high) else begin
                $display("%s: read request for block %0d outside the expected range",
                         test_name, sd_lba);
                other_errors++;
            end
        end
        if (ready_watch && ready) begin
            ready_seen = 1'b1;
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        seed         = 32'h8fe0e62c;
        value_errors = 0;
        other_errors = 0;
        reset        = 1'b1;
        img_mounted  = 1'b0;
        track_id     = 8'd0;
        bit_addr     = '0;
        probe_valid  = 1'b0;
        probe_expect = '0;
        stage_valid  = 1'b0;
        lba_watch    = 1'b0;
        lba_low      = '0;
        lba_high     = '0;
        ready_watch  = 1'b0;
        ready_seen   = 1'b0;
        test_name    = "reset";
        build_image(1'b1);
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("ready", 0, ready);
        check_value("busy", 0, busy);
        check_value("sd_rd", 0, sd_rd);
        check_value("disk_mounted", 0, disk_mounted);

        test_name   = "mount";
        img_mounted = 1'b1;
        #1;
        check_value("disk_mounted", 1, disk_mounted);
        @(negedge clk);
        check_value("busy", 1, busy);
        wait_status(1'b1, 1'b1);
        check_value("busy", 0, busy);
        check_value("bit_count", ref_bit_count(0), bit_count);
        sample_track(0, 64);

        test_name = "seek";
        lba_low   = ref_start(2);
        lba_high  = ref_start(2) + ref_blocks(2);
        lba_watch = 1'b1;
        track_id  = 8'd2;
        @(negedge clk);
        check_value("ready", 0, ready);
        wait_status(1'b1, 1'b1);
        lba_watch = 1'b0;
        check_value("bit_count", ref_bit_count(2), bit_count);
        sample_track(2, 64);

        // An empty range means any request at all is reported
        test_name = "empty track";
        lba_low   = '0;
        lba_high  = '0;
        lba_watch = 1'b1;
        track_id  = 8'd5;
        @(negedge clk);
        check_value("ready", 0, ready);
        wait_status(1'b1, 1'b1);
        lba_watch = 1'b0;
        check_value("bit_count", ref_bit_count(5), bit_count);

        test_name   = "unmount";
        img_mounted = 1'b0;
        #1;
        check_value("disk_mounted", 0, disk_mounted);
        check_value("ready", 1, ready);
        @(negedge clk);
        check_value("ready", 0, ready);
        check_value("busy", 0, busy);

        test_name = "failed scan";
        build_image(1'b0);
        first_block = blocks_served;
        ready_seen  = 1'b0;
        ready_watch = 1'b1;
        img_mounted = 1'b1;
        @(negedge clk);
        check_value("busy", 1, busy);
        wait_status(1'b0, 1'b0);
        ready_watch = 1'b0;
        check_value("disk_mounted", 0, disk_mounted);
        assert (blocks_served - first_block > SCAN_LIMIT) else begin
            $display("%s: scan gave up after only %0d blocks", test_name,
                     blocks_served - first_block);
            other_errors++;
        end
        assert (!ready_seen) else begin
            $display("%s: ready went high although the image has no track table", test_name);
            other_errors++;
        end

        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sim/woz_image_model.sv
module woz_image_model
    import woz_pkg::*;
#(
    parameter int IMAGE_BYTES = 16384
) (
    input  logic                   clk,
    input  lba_t                   sd_lba,
    input  logic                   sd_rd,
    output logic                   sd_ack,
    output logic [BUFF_ADDR_W-1:0] sd_buff_addr,
    output byte_t                  sd_buff_dout,
    output logic                   sd_buff_wr,
    output int                     blocks_served
);

    localparam int IMAGE_BLOCKS = IMAGE_BYTES / 512;

    byte_t  image [IMAGE_BYTES];
    integer seed;

    // One block: access delay, ack rise, 512 strobed bytes, ack fall
    task automatic serve_block(input lba_t lba);
        int base;
        int gap;
        base = int'(lba % IMAGE_BLOCKS) * 512;
        gap  = 1 + int'($unsigned($random(seed)) % 5);
        repeat (gap) @(negedge clk);
        sd_ack = 1'b1;
        @(negedge clk);
        for (int i = 0; i < 512; i++) begin
            // Mostly back to back, with a few idle cycles
            gap = int'($unsigned($random(seed)) % 8);
            if (gap > 2) begin
                gap = 0;
            end
            sd_buff_wr = 1'b0;
            repeat (gap) @(negedge clk);
            sd_buff_wr   = 1'b1;
            sd_buff_addr = BUFF_ADDR_W'(i);
            sd_buff_dout = image[base + i];
            @(negedge clk);
        end
        sd_buff_wr = 1'b0;
        @(negedge clk);
        sd_ack = 1'b0;
        blocks_served++;
        @(negedge clk);
    endtask

    // Host side, driven on the falling edge
    initial begin
        seed          = 32'h8fe0e62c;
        sd_ack        = 1'b0;
        sd_buff_addr  = '0;
        sd_buff_dout  = '0;
        sd_buff_wr    = 1'b0;
        blocks_served = 0;
        forever begin
            @(negedge clk);
            if (sd_rd) begin
                serve_block(sd_lba);
            end
        end
    end

endmodule

// File: verilog/woz_track_loader.sv
module woz_track_loader
    import woz_pkg::*;
#(
    parameter int SCAN_BLOCK_LIMIT = 256
) (
    input  logic                    clk,
    input  logic                    reset,
    // SD block device
    output lba_t                    sd_lba,
    output logic                    sd_rd,
    input  logic                    sd_ack,
    input  logic [BUFF_ADDR_W-1:0]  sd_buff_addr,
    input  byte_t                   sd_buff_dout,
    input  logic                    sd_buff_wr,
    // Drive side
    input  logic                    img_mounted,
    input  track_id_t               track_id,
    output logic                    ready,
    output logic                    disk_mounted,
    output logic                    busy,
    output logic [31:0]             bit_count,
    input  logic [TRACK_ADDR_W-1:0] bit_addr,
    output byte_t                   bit_data
);

    logic                   block_start, block_done, byte_valid;
    lba_t                   block_lba;
    logic [BUFF_ADDR_W-1:0] byte_addr;
    byte_t                  byte_data;
    logic                   scan_clear, scan_active, tables_found;
    logic [META_ADDR_W-1:0] meta_addr, meta_raddr;
    logic                   meta_we;
    byte_t                  meta_din, meta_rdata;
    logic                   lookup_start, lookup_done, track_empty;
    track_id_t              lookup_track;
    logic [15:0]            start_block, block_count, load_block;
    logic [31:0]            track_bits;
    logic                   load_active;

    // Track buffer write side
    logic [TRACK_ADDR_W-1:0] track_waddr;
    logic                    track_we;
    assign track_waddr = {load_block[4:0], byte_addr};
    assign track_we    = byte_valid && load_active;

    sd_block_reader u_reader (
        .clk, .reset, .block_start, .block_lba, .sd_ack, .sd_buff_addr,
        .sd_buff_dout, .sd_buff_wr, .sd_lba, .sd_rd, .block_done,
        .byte_valid, .byte_addr, .byte_data
    );

    woz_chunk_parser u_parser (
        .clk, .reset, .scan_clear, .scan_active, .byte_valid, .byte_data,
        .meta_addr, .meta_we, .meta_din, .tables_found
    );

    track_entry_lookup u_lookup (
        .clk, .reset, .lookup_start, .lookup_track, .meta_rdata, .meta_raddr,
        .lookup_done, .track_empty, .start_block, .block_count, .track_bits
    );

    disk_controller #(.SCAN_BLOCK_LIMIT(SCAN_BLOCK_LIMIT)) u_ctrl (
        .clk, .reset, .img_mounted, .track_id, .block_done, .tables_found,
        .lookup_done, .track_empty, .start_block, .block_count, .track_bits,
        .block_start, .block_lba, .scan_clear, .scan_active, .lookup_start,
        .lookup_track, .load_active, .load_block, .ready, .busy, .bit_count,
        .disk_mounted
    );

    dual_port_ram #(.ADDR_W(META_ADDR_W)) meta_ram (
        .clk, .addr_a(meta_addr), .we_a(meta_we), .din_a(meta_din), .dout_a(),
        .addr_b(meta_raddr), .dout_b(meta_rdata)
    );

    dual_port_ram #(.ADDR_W(TRACK_ADDR_W)) track_ram (
        .clk, .addr_a(track_waddr), .we_a(track_we), .din_a(byte_data), .dout_a(),
        .addr_b(bit_addr), .dout_b(bit_data)
    );

endmodule

// File: verilog/disk_controller.sv
module disk_controller
    import woz_pkg::*;
#(
    parameter int SCAN_BLOCK_LIMIT = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        img_mounted,
    input  track_id_t   track_id,
    input  logic        block_done,
    input  logic        tables_found,
    input  logic        lookup_done,
    input  logic        track_empty,
    input  logic [15:0] start_block,
    input  logic [15:0] block_count,
    input  logic [31:0] track_bits,
    output logic        block_start,
    output lba_t        block_lba,
    output logic        scan_clear,
    output logic        scan_active,
    output logic        lookup_start,
    output track_id_t   lookup_track,
    output logic        load_active,
    output logic [15:0] load_block,
    output logic        ready,
    output logic        busy,
    output logic [31:0] bit_count,
    output logic        disk_mounted
);

    localparam logic [15:0] SCAN_LIMIT = 16'(SCAN_BLOCK_LIMIT);

    typedef enum logic [2:0] {S_INIT, S_SCAN, S_IDLE, S_LOOKUP, S_LOAD} state_t;

    state_t      state;
    logic        prev_mounted;
    logic        scan_failed;
    logic [15:0] scan_blocks;
    logic        cached_valid;
    track_id_t   cached_track;
    logic        track_done;

    assign disk_mounted = img_mounted && !scan_failed;
    assign scan_active  = (state == S_SCAN);
    assign load_active  = (state == S_LOAD);

    // Last block of the track, or a lookup with nothing to fetch
    assign track_done = (state == S_LOAD && block_done && load_block + 16'd1 >= block_count) ||
                        (state == S_LOOKUP && lookup_done &&
                         (track_empty || block_count == 16'd0));

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_INIT;
            prev_mounted <= 1'b0;
            scan_failed  <= 1'b0;
            scan_blocks  <= '0;
            cached_valid <= 1'b0;
            ready        <= 1'b0;
            busy         <= 1'b0;
            bit_count    <= '0;
            block_start  <= 1'b0;
            scan_clear   <= 1'b0;
            lookup_start <= 1'b0;
        end else begin
            prev_mounted <= img_mounted;
            block_start  <= 1'b0;
            scan_clear   <= 1'b0;
            lookup_start <= 1'b0;

            case (state)
                S_SCAN: if (block_done) begin
                    scan_blocks <= scan_blocks + 16'd1;
                    if (tables_found) begin
                        state <= S_IDLE;
                    end else if (scan_blocks >= SCAN_LIMIT) begin
                        state       <= S_INIT;
                        busy        <= 1'b0;
                        scan_failed <= 1'b1;
                    end else begin
                        block_lba   <= block_lba + 32'd1;
                        block_start <= 1'b1;
                    end
                end
                S_IDLE: if (!cached_valid || track_id != cached_track) begin
                    state        <= S_LOOKUP;
                    lookup_track <= track_id;
                    lookup_start <= 1'b1;
                    ready        <= 1'b0;
                    busy         <= 1'b1;
                end
                S_LOOKUP: if (lookup_done && !track_done) begin
                    state       <= S_LOAD;
                    block_lba   <= {16'd0, start_block};
                    load_block  <= '0;
                    block_start <= 1'b1;
                end
                S_LOAD: if (block_done && !track_done) begin
                    load_block  <= load_block + 16'd1;
                    block_lba   <= block_lba + 32'd1;
                    block_start <= 1'b1;
                end
                default: ;
            endcase

            if (track_done) begin
                state        <= S_IDLE;
                cached_valid <= 1'b1;
                cached_track <= lookup_track;
                bit_count    <= track_empty ? 32'd0 : track_bits;
                ready        <= 1'b1;
                busy         <= 1'b0;
            end

            // ==================================================
            // Mount and unmount edges win over the FSM
            // ==================================================
            if (img_mounted && !prev_mounted) begin
                state        <= S_SCAN;
                scan_failed  <= 1'b0;
                scan_blocks  <= '0;
                cached_valid <= 1'b0;
                ready        <= 1'b0;
                busy         <= 1'b1;
                scan_clear   <= 1'b1;
                block_lba    <= '0;
                block_start  <= 1'b1;
            end else if (!img_mounted && prev_mounted) begin
                state        <= S_INIT;
                scan_failed  <= 1'b0;
                cached_valid <= 1'b0;
                ready        <= 1'b0;
                busy         <= 1'b0;
                bit_count    <= '0;
                block_start  <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(ready && busy));

endmodule

// File: verilog/track_entry_lookup.sv
module track_entry_lookup
    import woz_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   lookup_start,
    input  track_id_t              lookup_track,
    input  byte_t                  meta_rdata,
    output logic [META_ADDR_W-1:0] meta_raddr,
    output logic                   lookup_done,
    output logic                   track_empty,
    output logic [15:0]            start_block,
    output logic [15:0]            block_count,
    output logic [31:0]            track_bits
);

    logic        active;
    logic [4:0]  step;
    logic [63:0] entry;

    // TRKS entry is start block, block count, bit count, all little-endian
    assign start_block = entry[15:0];
    assign block_count = entry[31:16];
    assign track_bits  = entry[63:32];

    // Each byte is a read and a wait, TMAP first, then the 8 entry bytes
    always_ff @(posedge clk) begin
        if (reset) begin
            active      <= 1'b0;
            step        <= '0;
            lookup_done <= 1'b0;
            track_empty <= 1'b0;
        end else begin
            lookup_done <= 1'b0;
            if (lookup_start) begin
                active     <= 1'b1;
                step       <= 5'd1;
                meta_raddr <= META_TMAP_BASE + {3'b000, lookup_track};
            end else if (active) begin
                step <= step + 5'd1;
                if (step == 5'd2) begin
                    // Empty tracks still run the full sequence
                    track_empty <= (meta_rdata == TMAP_EMPTY);
                    meta_raddr  <= META_TRKS_BASE + {meta_rdata, 3'b000};
                end else if (step >= 5'd4 && step <= 5'd18 && !step[0]) begin
                    entry <= {meta_rdata, entry[63:8]};
                    meta_raddr <= meta_raddr + 1'b1;
                end else if (step == 5'd19) begin
                    active      <= 1'b0;
                    lookup_done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/woz_chunk_parser.sv
module woz_chunk_parser
    import woz_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   scan_clear,
    input  logic                   scan_active,
    input  logic                   byte_valid,
    input  byte_t                  byte_data,
    output logic [META_ADDR_W-1:0] meta_addr,
    output logic                   meta_we,
    output byte_t                  meta_din,
    output logic                   tables_found
);

    logic [3:0]  hdr_pos;
    logic [2:0]  chunk_hdr_pos;
    logic [31:0] chunk_id;
    logic [31:0] size_acc;
    logic [31:0] chunk_left;
    logic [31:0] chunk_index;
    logic        have_info;
    logic        have_tmap;
    logic        have_trks;

    assign tables_found = have_info && have_tmap && have_trks;

    always_ff @(posedge clk) begin
        if (reset || scan_clear) begin
            hdr_pos       <= '0;
            chunk_hdr_pos <= '0;
            chunk_id      <= '0;
            size_acc      <= '0;
            chunk_left    <= '0;
            chunk_index   <= '0;
            have_info     <= 1'b0;
            have_tmap     <= 1'b0;
            have_trks     <= 1'b0;
            meta_we       <= 1'b0;
        end else begin
            meta_we <= 1'b0;
            if (scan_active && byte_valid) begin
                if (hdr_pos < 4'(WOZ_HEADER_BYTES)) begin
                    // File header, signature and CRC ignored
                    hdr_pos <= hdr_pos + 4'd1;
                end else if (chunk_left == '0) begin
                    // Chunk header, 4-byte id then little-endian size
                    chunk_hdr_pos <= chunk_hdr_pos + 3'd1;
                    if (chunk_hdr_pos < 3'd4) begin
                        chunk_id <= {chunk_id[23:0], byte_data};
                    end else if (chunk_hdr_pos == 3'd7) begin
                        chunk_left  <= {byte_data, size_acc[31:8]};
                        chunk_index <= '0;
                    end else begin
                        size_acc <= {byte_data, size_acc[31:8]};
                    end
                end else begin
                    // Chunk body
                    if (chunk_id == CHUNK_INFO) begin
                        have_info <= 1'b1;
                    end else if (chunk_id == CHUNK_TMAP && chunk_index < TMAP_ENTRIES) begin
                        meta_addr <= META_TMAP_BASE + chunk_index[META_ADDR_W-1:0];
                        meta_din  <= byte_data;
                        meta_we   <= 1'b1;
                        if (chunk_index == TMAP_ENTRIES - 1) begin
                            have_tmap <= 1'b1;
                        end
                    end else if (chunk_id == CHUNK_TRKS && chunk_index < TRKS_BYTES) begin
                        meta_addr <= META_TRKS_BASE + chunk_index[META_ADDR_W-1:0];
                        meta_din  <= byte_data;
                        meta_we   <= 1'b1;
                        if (chunk_index == TRKS_BYTES - 1) begin
                            have_trks <= 1'b1;
                        end
                    end
                    chunk_index <= chunk_index + 32'd1;
                    chunk_left  <= chunk_left - 32'd1;
                    if (chunk_left == 32'd1) begin
                        chunk_id <= '0;
                        size_acc <= '0;
                    end
                end
            end
        end
    end

    // Metadata writes must land inside the controller's scan window
    assert property (@(posedge clk) disable iff (reset) meta_we |-> scan_active);

endmodule

// File: verilog/sd_block_reader.sv
module sd_block_reader
    import woz_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   block_start,
    input  lba_t                   block_lba,
    input  logic                   sd_ack,
    input  logic [BUFF_ADDR_W-1:0] sd_buff_addr,
    input  byte_t                  sd_buff_dout,
    input  logic                   sd_buff_wr,
    output lba_t                   sd_lba,
    output logic                   sd_rd,
    output logic                   block_done,
    output logic                   byte_valid,
    output logic [BUFF_ADDR_W-1:0] byte_addr,
    output byte_t                  byte_data
);

    logic pending;
    logic old_ack;
    logic xfer_active;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending     <= 1'b0;
            old_ack     <= 1'b0;
            xfer_active <= 1'b0;
            sd_rd       <= 1'b0;
            block_done  <= 1'b0;
            byte_valid  <= 1'b0;
        end else begin
            old_ack    <= sd_ack;
            block_done <= 1'b0;
            if (block_start) begin
                pending <= 1'b1;
                sd_lba  <= block_lba;
            end
            // Only a rise seen while requesting opens a transfer
            if (!old_ack && sd_ack && sd_rd) begin
                xfer_active <= 1'b1;
            end
            // Falls without a matching rise are dropped here
            if (old_ack && !sd_ack && xfer_active) begin
                xfer_active <= 1'b0;
                pending     <= 1'b0;
                block_done  <= 1'b1;
            end
            // Request is a level, held only while ack is low
            sd_rd      <= (pending || block_start) && !sd_ack && !xfer_active;
            byte_valid <= sd_ack && sd_buff_wr && pending;
        end
    end

    // Byte payload, one cycle behind the host strobe
    always_ff @(posedge clk) begin
        byte_addr <= sd_buff_addr;
        byte_data <= sd_buff_dout;
    end

    // Every accepted byte belongs to a transfer opened by this reader
    assert property (@(posedge clk) disable iff (reset) byte_valid |-> xfer_active);

endmodule

// File: verilog/dual_port_ram.sv
module dual_port_ram
    import woz_pkg::*;
#(
    parameter int ADDR_W = 11
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr_a,
    input  logic              we_a,
    input  byte_t             din_a,
    output byte_t             dout_a,
    input  logic [ADDR_W-1:0] addr_b,
    output byte_t             dout_b
);

    byte_t mem [0:(1 << ADDR_W) - 1];

    // Port A, write and read
    always_ff @(posedge clk) begin
        if (we_a) begin
            mem[addr_a] <= din_a;
        end
        dout_a <= mem[addr_a];
    end

    // Port B, read only
    always_ff @(posedge clk) begin
        dout_b <= mem[addr_b];
    end

endmodule

// File: verilog/woz_pkg.sv
package woz_pkg;

    // ==================================================
    // Shared types
    // ==================================================
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] lba_t;
    typedef logic [7:0]  track_id_t;

    // ==================================================
    // Address widths
    // ==================================================
    localparam int BUFF_ADDR_W  = 9;   // Byte within a 512-byte block
    localparam int META_ADDR_W  = 11;  // 2 KB metadata cache
    localparam int TRACK_ADDR_W = 14;  // 16 KB track buffer, 32 blocks

    // ==================================================
    // WOZ layout
    // ==================================================
    localparam logic [META_ADDR_W-1:0] META_TMAP_BASE = 11'd0;
    localparam logic [META_ADDR_W-1:0] META_TRKS_BASE = 11'd256;

    localparam int TMAP_ENTRIES     = 160;
    localparam int TRKS_BYTES       = 1280;  // 160 entries of 8 bytes
    localparam int WOZ_HEADER_BYTES = 12;

    localparam byte_t TMAP_EMPTY = 8'hFF;

    // Chunk ids, first file byte in the high byte
    localparam logic [31:0] CHUNK_INFO = 32'h494E_464F;
    localparam logic [31:0] CHUNK_TMAP = 32'h544D_4150;
    localparam logic [31:0] CHUNK_TRKS = 32'h5452_4B53;

endpackage
